//--- common/axi_ctrl_cfg.svh
`ifndef AXI_CTRL_CFG_SVH
`define AXI_CTRL_CFG_SVH

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------
`define AXI_DATA_W 32
`define LS_ADDR_W 15
`define SS_ADDR_W 28
`define STRB_W 4
`define USER_W 2

// both input FIFOs
`define FIFO_DEPTH 8

// ------------------------------------------------------------
// local address map, LS byte addresses
// ------------------------------------------------------------
`define MB_LOW 15'h2000
`define MB_HIGH 15'h201F
`define MB_COUNT 8

// interrupt enable at +0, interrupt status at +4
`define AA_LOW 15'h2100
`define AA_HIGH 15'h2107

// top of the local window, everything past it is unsupported too
`define LOCAL_HIGH 15'h2FFF

// stream user code for a two-beat remote write
`define USER_REMOTE_WR 2'b01

`endif

//--- common/bk_pkg.sv
`include "axi_ctrl_cfg.svh"

package bk_pkg;

    // ------------------------------------------------------------
    // plain vectors of the backend ports
    // ------------------------------------------------------------
    typedef logic [`AXI_DATA_W-1:0] data_t;
    typedef logic [`LS_ADDR_W-1:0] ls_addr_t;
    typedef logic [`STRB_W-1:0] strb_t;
    typedef logic [`USER_W-1:0] user_t;

    // ------------------------------------------------------------
    // FIFO and stream payloads
    // ------------------------------------------------------------

    // one LS request, reads carry zero data and strobes
    typedef struct packed {
        logic is_read;
        ls_addr_t addr;
        data_t wdata;
        strb_t strb;
    } ls_req_t;

    // one beat taken from SS
    typedef struct packed {
        data_t data;
        user_t user;
    } ss_beat_t;

    // one beat sent on SM
    typedef struct packed {
        data_t data;
        user_t user;
    } sm_beat_t;

endpackage

//--- common/ctrl_pkg.sv
`include "axi_ctrl_cfg.svh"

package ctrl_pkg;

    // dispatcher states
    typedef enum logic [2:0] {
        WAIT_DATA,
        DECIDE,
        MOVE,
        SEND_SM,
        TRIG_INT
    } disp_state_t;

    // request source for round robin
    typedef enum logic {
        LS,
        SS
    } src_t;

    // word index inside the mailbox or control block
    typedef logic [$clog2(`MB_COUNT)-1:0] reg_idx_t;

    // one register access, enables last a single cycle
    typedef struct packed {
        logic wr;
        logic rd;
        logic is_ctrl;
        reg_idx_t idx;
        bk_pkg::data_t wdata;
        bk_pkg::strb_t strb;
    } reg_access_t;

endpackage

//--- src/req_fifo.sv
module req_fifo #(
    parameter int width = 32,
    parameter int depth = 8
) (
    input  logic axi_aclk,
    input  logic axi_aresetn,
    input  logic wr_vld,
    input  logic [width-1:0] data_in,
    output logic wr_rdy,
    output logic rd_vld,
    output logic [width-1:0] data_out,
    input  logic rd_rdy
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = ptr_w + 1;

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic push;
    logic pop;

    assign wr_rdy = (count != cnt_w'(depth));
    assign rd_vld = (count != '0);
    assign push = wr_vld && wr_rdy;
    assign pop = rd_rdy && rd_vld;
    assign data_out = mem[rd_ptr];

    // storage, no reset
    always_ff @(posedge axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // pointers wrap at depth, which need not be a power of two
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    // reader must only pop a non-empty FIFO
    a_no_pop_empty: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        rd_rdy |-> rd_vld);

    a_count_bound: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        count <= cnt_w'(depth));

endmodule

//--- dispatch/dispatch_fsm.sv
`include "axi_ctrl_cfg.svh"

module dispatch_fsm (
    input  logic axi_aclk,
    input  logic axi_aresetn,
    input  logic ls_vld,
    input  bk_pkg::ls_req_t ls_head,
    output logic ls_pop,
    input  logic ss_vld,
    input  bk_pkg::ss_beat_t ss_head,
    output logic ss_pop,
    output ctrl_pkg::reg_access_t reg_acc,
    input  bk_pkg::data_t reg_rdata,
    output logic int_req,
    output bk_pkg::data_t ls_rdata,
    output logic ls_rdone,
    output bk_pkg::sm_beat_t sm_beat,
    output logic sm_start,
    input  logic sm_done
);

    ctrl_pkg::disp_state_t state;
    ctrl_pkg::src_t cur_src;
    ctrl_pkg::src_t last_src;

    bk_pkg::ls_req_t ls_req_q;
    bk_pkg::data_t first_q;
    bk_pkg::data_t second_q;
    logic have_first;
    logic beat_sel;

    logic ls_mb;
    logic ls_aa;
    logic ss_wr_beat;
    logic [`SS_ADDR_W-1:0] ss_addr;
    logic ss_mb;

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------
    assign ls_mb = (ls_req_q.addr >= `MB_LOW) && (ls_req_q.addr <= `MB_HIGH);
    assign ls_aa = (ls_req_q.addr >= `AA_LOW) && (ls_req_q.addr <= `AA_HIGH);

    // remote write from SS, first beat is {strb, addr}
    assign ss_addr = first_q[`SS_ADDR_W-1:0];
    assign ss_mb = (ss_addr >= `MB_LOW) && (ss_addr <= `MB_HIGH);

    // the head is taken in DECIDE, one pop per request or beat
    assign ls_pop = (state == ctrl_pkg::DECIDE) && (cur_src == ctrl_pkg::LS);
    assign ss_pop = (state == ctrl_pkg::DECIDE) && (cur_src == ctrl_pkg::SS);
    assign ss_wr_beat = ss_pop && (ss_head.user == `USER_REMOTE_WR);

    assign int_req = (state == ctrl_pkg::TRIG_INT);

    always_comb begin
        reg_acc = '0;
        if (state == ctrl_pkg::MOVE) begin
            if (cur_src == ctrl_pkg::LS) begin
                reg_acc.wr = !ls_req_q.is_read && (ls_mb || ls_aa);
                reg_acc.rd = ls_req_q.is_read && (ls_mb || ls_aa);
                reg_acc.is_ctrl = ls_aa;
                reg_acc.idx = ls_req_q.addr[4:2];
                reg_acc.wdata = ls_req_q.wdata;
                reg_acc.strb = ls_req_q.strb;
            end else begin
                // only in-range remote writes get here
                reg_acc.wr = 1'b1;
                reg_acc.idx = ss_addr[4:2];
                reg_acc.wdata = second_q;
                reg_acc.strb = first_q[`AXI_DATA_W-1 -: `STRB_W];
            end
        end
    end

    // request payloads
    always_ff @(posedge axi_aclk) begin
        if (ls_pop) begin
            ls_req_q <= ls_head;
        end
        if (ss_wr_beat && !have_first) begin
            first_q <= ss_head.data;
        end
        if (ss_wr_beat && have_first) begin
            second_q <= ss_head.data;
        end
    end

    // ------------------------------------------------------------
    // main FSM
    // ------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state <= ctrl_pkg::WAIT_DATA;
            cur_src <= ctrl_pkg::LS;
            last_src <= ctrl_pkg::SS;
            have_first <= 1'b0;
            beat_sel <= 1'b0;
            ls_rdata <= '0;
            ls_rdone <= 1'b0;
            sm_beat <= '0;
            sm_start <= 1'b0;
        end else begin
            ls_rdone <= 1'b0;
            sm_start <= 1'b0;
            case (state)
                ctrl_pkg::WAIT_DATA: begin
                    if (ls_vld || ss_vld) begin
                        // round robin, the source not served last wins a tie
                        if (ls_vld && (!ss_vld || last_src == ctrl_pkg::SS)) begin
                            cur_src <= ctrl_pkg::LS;
                        end else begin
                            cur_src <= ctrl_pkg::SS;
                        end
                        state <= ctrl_pkg::DECIDE;
                    end
                end
                ctrl_pkg::DECIDE: begin
                    last_src <= cur_src;
                    if (cur_src == ctrl_pkg::LS) begin
                        state <= ctrl_pkg::MOVE;
                    end else if (!ss_wr_beat) begin
                        // unknown user code, beat dropped
                        state <= ctrl_pkg::WAIT_DATA;
                    end else if (!have_first) begin
                        have_first <= 1'b1;
                        state <= ctrl_pkg::WAIT_DATA;
                    end else begin
                        have_first <= 1'b0;
                        state <= ss_mb ? ctrl_pkg::MOVE : ctrl_pkg::WAIT_DATA;
                    end
                end
                ctrl_pkg::MOVE: begin
                    if (cur_src == ctrl_pkg::SS) begin
                        state <= ctrl_pkg::TRIG_INT;
                    end else if (ls_req_q.is_read) begin
                        ls_rdata <= (ls_mb || ls_aa) ? reg_rdata : '1;
                        ls_rdone <= 1'b1;
                        state <= ctrl_pkg::WAIT_DATA;
                    end else if (ls_mb) begin
                        // forward the mailbox write, beat 0 is {strb, 0, addr}
                        sm_beat.data <= {ls_req_q.strb,
                                         {(`AXI_DATA_W - `STRB_W - `LS_ADDR_W){1'b0}},
                                         ls_req_q.addr};
                        sm_beat.user <= `USER_REMOTE_WR;
                        sm_start <= 1'b1;
                        beat_sel <= 1'b0;
                        state <= ctrl_pkg::SEND_SM;
                    end else begin
                        state <= ctrl_pkg::WAIT_DATA;
                    end
                end
                ctrl_pkg::SEND_SM: begin
                    if (sm_done && !sm_start) begin
                        if (!beat_sel) begin
                            sm_beat.data <= ls_req_q.wdata;
                            sm_start <= 1'b1;
                            beat_sel <= 1'b1;
                        end else begin
                            state <= ctrl_pkg::WAIT_DATA;
                        end
                    end
                end
                ctrl_pkg::TRIG_INT: begin
                    state <= ctrl_pkg::WAIT_DATA;
                end
                default: begin
                    state <= ctrl_pkg::WAIT_DATA;
                end
            endcase
        end
    end

    a_rdone_pulse: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        ls_rdone |=> !ls_rdone);

    a_sm_start_pulse: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        sm_start |=> !sm_start);

    a_no_pop_idle: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (state == ctrl_pkg::WAIT_DATA) |-> !(ls_pop || ss_pop));

endmodule

//--- dispatch/mailbox_regs.sv
`include "axi_ctrl_cfg.svh"

module mailbox_regs (
    input  logic axi_aclk,
    input  logic axi_aresetn,
    input  ctrl_pkg::reg_access_t reg_acc,
    output bk_pkg::data_t reg_rdata,
    input  logic int_req,
    output logic axi_interrupt
);

    bk_pkg::data_t mb [`MB_COUNT];
    logic int_en;
    logic int_sts;

    // ------------------------------------------------------------
    // read path
    // ------------------------------------------------------------
    // control words only have bit 0 with enable at offset 0 and status at offset 4
    always_comb begin
        reg_rdata = '0;
        if (reg_acc.rd) begin
            if (reg_acc.is_ctrl) begin
                reg_rdata[0] = reg_acc.idx[0] ? int_sts : int_en;
            end else begin
                reg_rdata = mb[reg_acc.idx];
            end
        end
    end

    // byte-strobed mailbox words
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            for (int i = 0; i < `MB_COUNT; i++) begin
                mb[i] <= '0;
            end
        end else if (reg_acc.wr && !reg_acc.is_ctrl) begin
            for (int b = 0; b < `STRB_W; b++) begin
                if (reg_acc.strb[b]) begin
                    mb[reg_acc.idx][8*b +: 8] <= reg_acc.wdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // interrupt enable, status and pulse
    // ------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            int_en <= 1'b0;
            int_sts <= 1'b0;
            axi_interrupt <= 1'b0;
        end else begin
            if (reg_acc.wr && reg_acc.is_ctrl && reg_acc.strb[0]) begin
                if (!reg_acc.idx[0]) begin
                    int_en <= reg_acc.wdata[0];
                end else if (reg_acc.wdata[0]) begin
                    // write 1 to clear
                    int_sts <= 1'b0;
                end
            end
            if (int_req && int_en) begin
                int_sts <= 1'b1;
            end
            axi_interrupt <= int_req && int_en;
        end
    end

    a_wr_rd_excl: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        !(reg_acc.wr && reg_acc.rd));

endmodule

//--- src/axi_ctrl_logic.sv
`include "axi_ctrl_cfg.svh"

module axi_ctrl_logic (
    input  logic axi_aclk,
    input  logic axi_aresetn,
    output logic axi_interrupt,

    // lite slave
    input  logic bk_ls_wstart,
    input  bk_pkg::ls_addr_t bk_ls_waddr,
    input  bk_pkg::data_t bk_ls_wdata,
    input  bk_pkg::strb_t bk_ls_wstrb,
    input  logic bk_ls_rstart,
    input  bk_pkg::ls_addr_t bk_ls_raddr,
    output bk_pkg::data_t bk_ls_rdata,
    output logic bk_ls_rdone,

    // stream master
    output logic bk_sm_start,
    output bk_pkg::data_t bk_sm_data,
    output bk_pkg::user_t bk_sm_user,
    input  logic bk_sm_done,

    // stream slave
    input  bk_pkg::data_t bk_ss_data,
    input  bk_pkg::user_t bk_ss_user,
    input  logic bk_ss_valid,
    output logic bk_ss_ready
);

    bk_pkg::ls_req_t ls_in;
    bk_pkg::ls_req_t ls_head;
    bk_pkg::ss_beat_t ss_in;
    bk_pkg::ss_beat_t ss_head;
    bk_pkg::sm_beat_t sm_beat;
    bk_pkg::data_t reg_rdata;
    ctrl_pkg::reg_access_t reg_acc;
    logic ls_wr_vld;
    logic ls_vld;
    logic ls_pop;
    logic ss_vld;
    logic ss_pop;
    logic int_req;

    // a request arriving on a full LS FIFO is lost
    assign ls_wr_vld = bk_ls_wstart || bk_ls_rstart;

    always_comb begin
        ls_in = '0;
        if (bk_ls_wstart) begin
            ls_in.addr = bk_ls_waddr;
            ls_in.wdata = bk_ls_wdata;
            ls_in.strb = bk_ls_wstrb;
        end else if (bk_ls_rstart) begin
            ls_in.is_read = 1'b1;
            ls_in.addr = bk_ls_raddr;
        end
    end

    assign ss_in.data = bk_ss_data;
    assign ss_in.user = bk_ss_user;

    req_fifo #(.width($bits(bk_pkg::ls_req_t)), .depth(`FIFO_DEPTH)) fifo_ls (
        .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
        .wr_vld(ls_wr_vld), .data_in(ls_in), .wr_rdy(),
        .rd_vld(ls_vld), .data_out(ls_head), .rd_rdy(ls_pop));

    req_fifo #(.width($bits(bk_pkg::ss_beat_t)), .depth(`FIFO_DEPTH)) fifo_ss (
        .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
        .wr_vld(bk_ss_valid), .data_in(ss_in), .wr_rdy(bk_ss_ready),
        .rd_vld(ss_vld), .data_out(ss_head), .rd_rdy(ss_pop));

    dispatch_fsm u_dispatch (
        .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
        .ls_vld(ls_vld), .ls_head(ls_head), .ls_pop(ls_pop),
        .ss_vld(ss_vld), .ss_head(ss_head), .ss_pop(ss_pop),
        .reg_acc(reg_acc), .reg_rdata(reg_rdata), .int_req(int_req),
        .ls_rdata(bk_ls_rdata), .ls_rdone(bk_ls_rdone),
        .sm_beat(sm_beat), .sm_start(bk_sm_start), .sm_done(bk_sm_done));

    mailbox_regs u_regs (
        .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
        .reg_acc(reg_acc), .reg_rdata(reg_rdata),
        .int_req(int_req), .axi_interrupt(axi_interrupt));

    assign bk_sm_data = sm_beat.data;
    assign bk_sm_user = sm_beat.user;

endmodule

//--- tb/tb_axi_ctrl.sv
`include "axi_ctrl_cfg.svh"

module tb_axi_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    logic axi_aclk = 1'b0;
    logic axi_aresetn;
    logic axi_interrupt;
    logic bk_ls_wstart;
    logic bk_ls_rstart;
    logic bk_ls_rdone;
    logic [14:0] bk_ls_waddr;
    logic [14:0] bk_ls_raddr;
    logic [31:0] bk_ls_wdata;
    logic [31:0] bk_ls_rdata;
    logic [31:0] bk_sm_data;
    logic [31:0] bk_ss_data;
    logic [3:0] bk_ls_wstrb;
    logic bk_sm_start;
    logic bk_sm_done;
    logic bk_ss_valid;
    logic bk_ss_ready;
    logic [1:0] bk_sm_user;
    logic [1:0] bk_ss_user;

    int errors = 0;
    int seed = 15;
    int int_count = 0;
    int exp_int = 0;
    logic sm_hold = 1'b0;
    logic [31:0] exp_rd[$];
    logic [31:0] exp_sm[$];

    // reference state
    logic [31:0] mb_ref[8];
    logic en_ref = 1'b0;
    logic sts_ref = 1'b0;

    axi_ctrl_logic UUT (.*);

    always #50 axi_aclk = ~axi_aclk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                          input logic [3:0] strb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = nw[8*b +: 8];
        end
        return r;
    endfunction

    // expected LS read data from the address map
    function automatic logic [31:0] ref_read(input logic [14:0] a);
        if (a >= `MB_LOW && a <= `MB_HIGH) return mb_ref[a[4:2]];
        if (a >= `AA_LOW && a <= `AA_HIGH) return a[2] ? {31'b0, sts_ref} : {31'b0, en_ref};
        return '1;
    endfunction

    task automatic ls_write(input logic [14:0] a, input logic [31:0] d, input logic [3:0] s);
        if (a >= `MB_LOW && a <= `MB_HIGH) begin
            mb_ref[a[4:2]] = merge(mb_ref[a[4:2]], d, s);
            exp_sm.push_back({s, 13'b0, a});
            exp_sm.push_back(d);
        end else if (a >= `AA_LOW && a <= `AA_HIGH && s[0]) begin
            if (!a[2]) en_ref = d[0];
            else if (d[0]) sts_ref = 1'b0;
        end
        bk_ls_wstart = 1'b1;
        bk_ls_waddr = a;
        bk_ls_wdata = d;
        bk_ls_wstrb = s;
        @(posedge axi_aclk);
        #5 bk_ls_wstart = 1'b0;
    endtask

    task automatic ls_read(input logic [14:0] a);
        exp_rd.push_back(ref_read(a));
        bk_ls_rstart = 1'b1;
        bk_ls_raddr = a;
        @(posedge axi_aclk);
        #5 bk_ls_rstart = 1'b0;
    endtask

    // one SS beat held until the FIFO takes it
    task automatic ss_send(input logic [31:0] d, input logic [1:0] u);
        int t;
        t = 0;
        bk_ss_data = d;
        bk_ss_user = u;
        bk_ss_valid = 1'b1;
        while (!bk_ss_ready && t < 2000) begin
            @(posedge axi_aclk);
            #5 t++;
        end
        if (t >= 2000) begin
            $display("timeout waiting for bk_ss_ready at %0t", $time);
            errors++;
        end
        @(posedge axi_aclk);
        #5 bk_ss_valid = 1'b0;
    endtask

    task automatic ss_remote(input logic [27:0] a, input logic [31:0] d, input logic [3:0] s);
        if (a >= `MB_LOW && a <= `MB_HIGH) begin
            mb_ref[a[4:2]] = merge(mb_ref[a[4:2]], d, s);
            if (en_ref) begin
                sts_ref = 1'b1;
                exp_int++;
            end
        end
        ss_send({s, a}, `USER_REMOTE_WR);
        ss_send(d, `USER_REMOTE_WR);
    endtask

    // idle needs empty FIFOs and queues plus an idle FSM on two checks in a row
    task automatic wait_drain();
        int t;
        int calm;
        t = 0;
        calm = 0;
        while (calm < 2 && t < 5000) begin
            if (exp_rd.size() == 0 && exp_sm.size() == 0 && !UUT.ls_vld && !UUT.ss_vld
                && UUT.u_dispatch.state == ctrl_pkg::WAIT_DATA && !bk_sm_start) calm++;
            else calm = 0;
            @(posedge axi_aclk);
            #5 t++;
        end
        if (t >= 5000) begin
            $display("timeout waiting for the DUT to go idle at %0t", $time);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // response checkers and SM responder
    // ------------------------------------------------------------
    always @(posedge axi_aclk) begin
        if (axi_interrupt) int_count++;
        if (bk_ls_rdone) begin
            if (exp_rd.size() == 0) begin
                $display("unexpected LS read response at %0t", $time);
                errors++;
            end else begin
                check("bk_ls_rdata", bk_ls_rdata, exp_rd.pop_front());
            end
        end
    end

    initial begin
        int d;
        int t;
        forever begin
            @(posedge axi_aclk);
            if (bk_sm_start) begin
                if (exp_sm.size() == 0) begin
                    $display("unexpected SM beat at %0t", $time);
                    errors++;
                end else begin
                    check("bk_sm_data", bk_sm_data, exp_sm.pop_front());
                    check("bk_sm_user", 32'(bk_sm_user), 32'(`USER_REMOTE_WR));
                end
                d = 1 + ($unsigned($random(seed)) % 4);
                repeat (d - 1) @(posedge axi_aclk);
                t = 0;
                while (sm_hold && t < 5000) begin
                    @(posedge axi_aclk);
                    t++;
                end
                if (t >= 5000) begin
                    $display("SM back-pressure was never released at %0t", $time);
                    errors++;
                end
                #5 bk_sm_done = 1'b1;
                @(posedge axi_aclk);
                #5 bk_sm_done = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        for (int i = 0; i < 8; i++) mb_ref[i] = '0;
        axi_aresetn = 1'b0;
        {bk_ls_wstart, bk_ls_rstart, bk_sm_done, bk_ss_valid} = '0;
        {bk_ls_waddr, bk_ls_raddr, bk_ls_wdata, bk_ls_wstrb} = '0;
        {bk_ss_data, bk_ss_user} = '0;
        repeat (2) @(posedge axi_aclk);
        #5 axi_aresetn = 1'b1;
        check("bk_ss_ready", 32'(bk_ss_ready), 32'd1);

        // strobe merge per mailbox word
        for (int i = 0; i < 8; i++) begin
            ls_write(15'(`MB_LOW + 4 * i), $random(seed), 4'hf);
            ls_write(15'(`MB_LOW + 4 * i), $random(seed), 4'(i * 5 + 3));
            ls_read(15'(`MB_LOW + 4 * i));
            wait_drain();
        end

        // unsupported and ignored addresses
        ls_write(15'h2108, 32'h1234_5678, 4'hf);
        ls_write(15'h2200, 32'hdead_beef, 4'hf);
        ls_write(15'h4000, 32'hcafe_f00d, 4'hf);
        ls_read(15'h2108);
        ls_read(15'h2ffc);
        ls_read(15'h3000);
        ls_read(15'h7ffc);
        wait_drain();
        for (int i = 0; i < 8; i++) ls_read(15'(`MB_LOW + 4 * i));
        ls_read(`AA_LOW);
        ls_read(15'h2104);
        wait_drain();

        // remote writes with the interrupt enabled and then disabled
        ls_write(`AA_LOW, 32'h1, 4'hf);
        ss_send(32'h5555_0000, 2'b00);
        ss_remote(28'h2014, 32'ha1b2_c3d4, 4'b0110);
        ss_remote(28'h3000, 32'h1111_1111, 4'hf);
        wait_drain();
        check("axi_interrupt count", 32'(int_count), 32'(exp_int));
        ls_read(15'h2104);
        ls_read(15'h2014);
        ls_write(15'h2104, 32'h1, 4'hf);
        ls_read(15'h2104);
        ls_write(`AA_LOW, 32'h0, 4'hf);
        wait_drain();
        ss_remote(28'h2018, 32'h0f0e_0d0c, 4'hf);
        wait_drain();
        ls_read(15'h2104);
        ls_read(15'h2018);
        wait_drain();
        check("axi_interrupt count", 32'(int_count), 32'(exp_int));

        // queued mix under SM back-pressure with SS on words 4..7 and LS on words 0..3
        sm_hold = 1'b1;
        ls_write(`MB_LOW, $random(seed), 4'hf);
        for (int i = 0; i < 7; i++) begin
            if ($random(seed) & 1)
                ls_write(15'(`MB_LOW + 4 * ($unsigned($random(seed)) % 4)),
                         $random(seed), 4'($random(seed)));
            else
                ls_read(15'(`MB_LOW + 4 * ($unsigned($random(seed)) % 4)));
        end
        for (int p = 0; p < 4; p++) begin
            ss_remote(28'(`MB_LOW + 16 + 4 * p), $random(seed), 4'($random(seed)));
        end
        check("bk_ss_ready", 32'(bk_ss_ready), 32'd0);
        sm_hold = 1'b0;
        wait_drain();
        for (int i = 0; i < 8; i++) ls_read(15'(`MB_LOW + 4 * i));
        wait_drain();
        check("axi_interrupt count", 32'(int_count), 32'(exp_int));

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/bk_pkg.sv
common/ctrl_pkg.sv
src/req_fifo.sv
dispatch/dispatch_fsm.sv
dispatch/mailbox_regs.sv
src/axi_ctrl_logic.sv
tb/tb_axi_ctrl.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_axi_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
